// File: fpu_defs.svh
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// operand word and one single-precision half
`define FPU_DATA_W 64
`define FPU_HALF_W 32

// lanes and result-bus slots
`define FPU_LANES 2
`define FPU_FWD_SRCS 10

// forward index width, and the index that means no forward
`define FPU_IDX_W 4
`define FPU_FWD_NONE 15

// exception flags and instruction tag
`define FPU_FLAG_W 11
`define FPU_TAG_W 9

// fpcsr flag-enable field, bits 21:11
// bit FPU_CSR_EN_LO+i enables flag i
`define FPU_CSR_EN_LO 11

`endif

// File: fpu_pkg.sv
`include "fpu_defs.svh"

package fpu_pkg;

  // low single in 31:0, high single in 63:32
  typedef logic [`FPU_DATA_W-1:0] fpu_data_t;

  // result-bus slot, FPU_FWD_NONE for no forward
  typedef logic [`FPU_IDX_W-1:0] fwd_idx_t;

  typedef logic [`FPU_FLAG_W-1:0] fpu_flags_t;

  typedef logic [`FPU_TAG_W-1:0] rob_tag_t;

  // 14-bit retire code
  typedef struct packed {
    logic [3:0] flag_idx;
    rob_tag_t   tag;
    logic       exc;
  } fpu_ret_t;

  typedef enum logic [2:0] {
    PERM_COPY_A   = 3'd0,
    PERM_COPY_B   = 3'd1,
    // halves of B exchanged
    PERM_SWAP_B   = 3'd2,
    // low half of B in both halves
    PERM_DUP_LO_B = 3'd3,
    // high half of A over low half of B
    PERM_MERGE    = 3'd4
  } perm_op_t;

endpackage

// File: fwd_bus_capture.sv
`include "fpu_defs.svh"

module fwd_bus_capture (
  input  logic               clk,
  input  logic               rst,
  input  fpu_pkg::fpu_data_t fwd_bus   [`FPU_FWD_SRCS],
  output fpu_pkg::fpu_data_t fwd_bus_q [`FPU_FWD_SRCS]
);

  // one-cycle-old copy of every bus slot
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `FPU_FWD_SRCS; s++) begin
        fwd_bus_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < `FPU_FWD_SRCS; s++) begin
        fwd_bus_q[s] <= fwd_bus[s];
      end
    end
  end

endmodule

// File: operand_forward.sv
`include "fpu_defs.svh"

module operand_forward (
  input  logic               clk,
  input  fpu_pkg::fpu_data_t reg_val,
  input  fpu_pkg::fpu_data_t fwd_bus   [`FPU_FWD_SRCS],
  input  fpu_pkg::fpu_data_t fwd_bus_q [`FPU_FWD_SRCS],
  input  fpu_pkg::fwd_idx_t  fwd_now,
  input  fpu_pkg::fwd_idx_t  fwd_old,
  output fpu_pkg::fpu_data_t operand
);

  logic now_hit;
  logic old_hit;

  assign now_hit = fwd_now < `FPU_IDX_W'(`FPU_FWD_SRCS);
  assign old_hit = fwd_old < `FPU_IDX_W'(`FPU_FWD_SRCS);

  // live bus first, then last cycle's bus, then register file
  always_comb begin
    if (now_hit) begin
      operand = fwd_bus[fwd_now];
    end else if (old_hit) begin
      operand = fwd_bus_q[fwd_old];
    end else begin
      operand = reg_val;
    end
  end

  // slots 10..14 do not exist on the bus
  a_now_idx_legal: assert property (@(posedge clk)
    now_hit || fwd_now == `FPU_IDX_W'(`FPU_FWD_NONE));

  a_old_idx_legal: assert property (@(posedge clk)
    old_hit || fwd_old == `FPU_IDX_W'(`FPU_FWD_NONE));

endmodule

// File: perm_lane.sv
`include "fpu_defs.svh"

module perm_lane (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  fpu_pkg::perm_op_t  op,
  input  logic               use_bx,
  input  fpu_pkg::fpu_data_t a,
  input  fpu_pkg::fpu_data_t b,
  input  fpu_pkg::fpu_data_t bx,
  input  fpu_pkg::fwd_idx_t  fwd_a_now,
  input  fpu_pkg::fwd_idx_t  fwd_a_old,
  input  fpu_pkg::fwd_idx_t  fwd_b_now,
  input  fpu_pkg::fwd_idx_t  fwd_b_old,
  input  fpu_pkg::fpu_data_t fwd_bus   [`FPU_FWD_SRCS],
  input  fpu_pkg::fpu_data_t fwd_bus_q [`FPU_FWD_SRCS],
  input  fpu_pkg::fpu_flags_t flags,
  input  fpu_pkg::rob_tag_t  tag,
  output fpu_pkg::fpu_data_t b_fwd,
  output fpu_pkg::fpu_data_t lane_res,
  output fpu_pkg::fpu_flags_t lane_flags,
  output fpu_pkg::rob_tag_t  lane_tag,
  output logic               lane_valid
);
  import fpu_pkg::*;

  fpu_data_t a_fwd;
  fpu_data_t b_op;
  fpu_data_t perm_res;

  operand_forward u_fwd_a (
    .clk       (clk),
    .reg_val   (a),
    .fwd_bus   (fwd_bus),
    .fwd_bus_q (fwd_bus_q),
    .fwd_now   (fwd_a_now),
    .fwd_old   (fwd_a_old),
    .operand   (a_fwd)
  );

  operand_forward u_fwd_b (
    .clk       (clk),
    .reg_val   (b),
    .fwd_bus   (fwd_bus),
    .fwd_bus_q (fwd_bus_q),
    .fwd_now   (fwd_b_now),
    .fwd_old   (fwd_b_old),
    .operand   (b_fwd)
  );

  // alternate operand replaces B after forwarding
  assign b_op = use_bx ? bx : b_fwd;

  always_comb begin
    case (op)
      PERM_COPY_A:   perm_res = a_fwd;
      PERM_COPY_B:   perm_res = b_op;
      PERM_SWAP_B:   perm_res = {b_op[`FPU_HALF_W-1:0], b_op[`FPU_DATA_W-1:`FPU_HALF_W]};
      PERM_DUP_LO_B: perm_res = {2{b_op[`FPU_HALF_W-1:0]}};
      PERM_MERGE:    perm_res = {a_fwd[`FPU_DATA_W-1:`FPU_HALF_W], b_op[`FPU_HALF_W-1:0]};
      default:       perm_res = a_fwd;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= en;
    end
  end

  // result, flags and tag travel together to retire
  always_ff @(posedge clk) begin
    if (en) begin
      lane_res   <= perm_res;
      lane_flags <= flags;
      lane_tag   <= tag;
    end
  end

  a_op_defined: assert property (@(posedge clk) disable iff (rst)
    en |-> op inside {PERM_COPY_A, PERM_COPY_B, PERM_SWAP_B, PERM_DUP_LO_B, PERM_MERGE});

endmodule

// File: fpu_retire.sv
`include "fpu_defs.svh"

module fpu_retire (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         fpcsr,
  input  fpu_pkg::fpu_data_t  lane_res   [`FPU_LANES],
  input  fpu_pkg::fpu_flags_t lane_flags [`FPU_LANES],
  input  fpu_pkg::rob_tag_t   lane_tag   [`FPU_LANES],
  input  logic                lane_valid [`FPU_LANES],
  output fpu_pkg::fpu_data_t  res        [`FPU_LANES],
  output fpu_pkg::fpu_ret_t   ret        [`FPU_LANES],
  output logic                ret_en     [`FPU_LANES]
);
  import fpu_pkg::*;

  fpu_flags_t flag_en;
  fpu_flags_t hit  [`FPU_LANES];
  fpu_ret_t   code [`FPU_LANES];

  // index of the lowest raised flag, 0 when none
  function automatic logic [3:0] lowest_set(input fpu_flags_t v);
    logic [3:0] idx;
    idx = 4'd0;
    for (int i = `FPU_FLAG_W - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = 4'(i);
      end
    end
    return idx;
  endfunction

  assign flag_en = fpcsr[`FPU_CSR_EN_LO +: `FPU_FLAG_W];

  always_comb begin
    for (int l = 0; l < `FPU_LANES; l++) begin
      hit[l]           = lane_flags[l] & flag_en;
      code[l].flag_idx = lowest_set(hit[l]);
      code[l].tag      = lane_tag[l];
      code[l].exc      = |hit[l];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int l = 0; l < `FPU_LANES; l++) begin
        res[l]    <= '0;
        ret[l]    <= '0;
        ret_en[l] <= 1'b0;
      end
    end else begin
      for (int l = 0; l < `FPU_LANES; l++) begin
        ret_en[l] <= lane_valid[l];
        // hold last result between retires
        if (lane_valid[l]) begin
          res[l] <= lane_res[l];
          ret[l] <= code[l];
        end
      end
    end
  end

  for (genvar l = 0; l < `FPU_LANES; l++) begin : g_chk
    a_no_ret_after_rst: assert property (@(posedge clk) rst |=> !ret_en[l]);
  end

endmodule

// File: fpu_perm_unit.sv
`include "fpu_defs.svh"

module fpu_perm_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                en         [`FPU_LANES],
  input  fpu_pkg::perm_op_t   op         [`FPU_LANES],
  input  logic                use_bx     [`FPU_LANES],
  input  fpu_pkg::fpu_data_t  a          [`FPU_LANES],
  input  fpu_pkg::fpu_data_t  b          [`FPU_LANES],
  input  fpu_pkg::fpu_data_t  bx         [`FPU_LANES],
  input  fpu_pkg::fwd_idx_t   fwd_a_now  [`FPU_LANES],
  input  fpu_pkg::fwd_idx_t   fwd_a_old  [`FPU_LANES],
  input  fpu_pkg::fwd_idx_t   fwd_b_now  [`FPU_LANES],
  input  fpu_pkg::fwd_idx_t   fwd_b_old  [`FPU_LANES],
  input  fpu_pkg::fpu_flags_t flags      [`FPU_LANES],
  input  fpu_pkg::rob_tag_t   tag        [`FPU_LANES],
  input  fpu_pkg::fpu_data_t  fwd_bus    [`FPU_FWD_SRCS],
  input  logic [31:0]         fpcsr,
  output fpu_pkg::fpu_data_t  b_fwd      [`FPU_LANES],
  output fpu_pkg::fpu_data_t  res        [`FPU_LANES],
  output fpu_pkg::fpu_ret_t   ret        [`FPU_LANES],
  output logic                ret_en     [`FPU_LANES]
);
  import fpu_pkg::*;

  fpu_data_t  fwd_bus_q  [`FPU_FWD_SRCS];
  fpu_data_t  lane_res   [`FPU_LANES];
  fpu_flags_t lane_flags [`FPU_LANES];
  rob_tag_t   lane_tag   [`FPU_LANES];
  logic       lane_valid [`FPU_LANES];

  fwd_bus_capture u_capture (
    .clk       (clk),
    .rst       (rst),
    .fwd_bus   (fwd_bus),
    .fwd_bus_q (fwd_bus_q)
  );

  for (genvar l = 0; l < `FPU_LANES; l++) begin : g_lane
    perm_lane u_lane (
      .clk        (clk),
      .rst        (rst),
      .en         (en[l]),
      .op         (op[l]),
      .use_bx     (use_bx[l]),
      .a          (a[l]),
      .b          (b[l]),
      .bx         (bx[l]),
      .fwd_a_now  (fwd_a_now[l]),
      .fwd_a_old  (fwd_a_old[l]),
      .fwd_b_now  (fwd_b_now[l]),
      .fwd_b_old  (fwd_b_old[l]),
      .fwd_bus    (fwd_bus),
      .fwd_bus_q  (fwd_bus_q),
      .flags      (flags[l]),
      .tag        (tag[l]),
      .b_fwd      (b_fwd[l]),
      .lane_res   (lane_res[l]),
      .lane_flags (lane_flags[l]),
      .lane_tag   (lane_tag[l]),
      .lane_valid (lane_valid[l])
    );
  end

  fpu_retire u_retire (
    .clk        (clk),
    .rst        (rst),
    .fpcsr      (fpcsr),
    .lane_res   (lane_res),
    .lane_flags (lane_flags),
    .lane_tag   (lane_tag),
    .lane_valid (lane_valid),
    .res        (res),
    .ret        (ret),
    .ret_en     (ret_en)
  );

endmodule

// File: tb_fpu_perm_unit.sv
`include "fpu_defs.svh"

module tb_fpu_perm_unit;
  timeunit 1ns;
  timeprecision 1ps;

  import fpu_pkg::*;

  typedef struct packed {
    fpu_data_t res;
    fpu_ret_t  ret;
    fpu_data_t b_fwd;
    int        due;
  } expect_t;

  localparam int DRAIN_LIMIT = 20;

  logic       clk;
  logic       rst;
  logic       en        [`FPU_LANES];
  perm_op_t   op        [`FPU_LANES];
  logic       use_bx    [`FPU_LANES];
  fpu_data_t  a         [`FPU_LANES];
  fpu_data_t  b         [`FPU_LANES];
  fpu_data_t  bx        [`FPU_LANES];
  fwd_idx_t   fwd_a_now [`FPU_LANES];
  fwd_idx_t   fwd_a_old [`FPU_LANES];
  fwd_idx_t   fwd_b_now [`FPU_LANES];
  fwd_idx_t   fwd_b_old [`FPU_LANES];
  fpu_flags_t flags     [`FPU_LANES];
  rob_tag_t   tag       [`FPU_LANES];
  fpu_data_t  fwd_bus   [`FPU_FWD_SRCS];
  logic [31:0] fpcsr;
  fpu_data_t  b_fwd     [`FPU_LANES];
  fpu_data_t  res       [`FPU_LANES];
  fpu_ret_t   ret       [`FPU_LANES];
  logic       ret_en    [`FPU_LANES];

  integer    seed = 81252;
  int        val_errs = 0;
  int        other_errs = 0;
  int        cyc = 0;
  rob_tag_t  next_tag [`FPU_LANES];
  fpu_data_t bus_prev [`FPU_FWD_SRCS];
  expect_t   exp_q    [`FPU_LANES][$];

  fpu_perm_unit dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // what the capture register holds after each edge
  always @(posedge clk) begin
    for (int s = 0; s < `FPU_FWD_SRCS; s++) begin
      bus_prev[s] <= rst ? '0 : fwd_bus[s];
    end
  end

  function automatic fpu_data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // mostly bus slots and sometimes no forward
  function automatic fwd_idx_t rand_idx();
    int r;
    r = $unsigned($random(seed)) % 16;
    if (r >= `FPU_FWD_SRCS) return fwd_idx_t'(`FPU_FWD_NONE);
    return fwd_idx_t'(r);
  endfunction

  function automatic fpu_data_t pick_operand(
    input fpu_data_t reg_val,
    input fwd_idx_t  now_idx,
    input fwd_idx_t  old_idx,
    input fpu_data_t bus     [`FPU_FWD_SRCS],
    input fpu_data_t bus_old [`FPU_FWD_SRCS]
  );
    if (int'(now_idx) < `FPU_FWD_SRCS) return bus[now_idx];
    if (int'(old_idx) < `FPU_FWD_SRCS) return bus_old[old_idx];
    return reg_val;
  endfunction

  function automatic expect_t reference_model(
    input fpu_data_t  ra,
    input fpu_data_t  rb,
    input fpu_data_t  rbx,
    input perm_op_t   pop,
    input logic       pbx,
    input fwd_idx_t   an,
    input fwd_idx_t   ao,
    input fwd_idx_t   bn,
    input fwd_idx_t   bo,
    input fpu_data_t  bus     [`FPU_FWD_SRCS],
    input fpu_data_t  bus_old [`FPU_FWD_SRCS],
    input fpu_flags_t fl,
    input rob_tag_t   tg,
    input fpu_flags_t csr_en
  );
    expect_t    e;
    fpu_data_t  op_a;
    fpu_data_t  op_b;
    fpu_flags_t hit;
    logic       found;
    e = '0;
    op_a = pick_operand(ra, an, ao, bus, bus_old);
    e.b_fwd = pick_operand(rb, bn, bo, bus, bus_old);
    op_b = pbx ? rbx : e.b_fwd;
    case (pop)
      PERM_COPY_A:   e.res = op_a;
      PERM_COPY_B:   e.res = op_b;
      PERM_SWAP_B:   e.res = {op_b[`FPU_HALF_W-1:0], op_b[`FPU_DATA_W-1:`FPU_HALF_W]};
      PERM_DUP_LO_B: e.res = {op_b[`FPU_HALF_W-1:0], op_b[`FPU_HALF_W-1:0]};
      // merge
      default:       e.res = {op_a[`FPU_DATA_W-1:`FPU_HALF_W], op_b[`FPU_HALF_W-1:0]};
    endcase
    hit = fl & csr_en;
    found = 1'b0;
    e.ret.exc = |hit;
    e.ret.tag = tg;
    e.ret.flag_idx = 4'd0;
    for (int i = 0; i < `FPU_FLAG_W; i++) begin
      if (hit[i] && !found) begin
        e.ret.flag_idx = 4'(i);
        found = 1'b1;
      end
    end
    return e;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int l = 0; l < `FPU_LANES; l++) begin
      n += exp_q[l].size();
    end
    return n;
  endfunction

  // bx_mode 0 off, 1 on, 2 random; op_sel below 0 picks a random op
  task automatic issue_cycle(input logic [`FPU_LANES-1:0] lane_mask, input logic fwd_on,
                             input int bx_mode, input int op_sel);
    expect_t    cur [`FPU_LANES];
    fpu_flags_t csr_en;
    @(negedge clk);
    csr_en = fpcsr[`FPU_CSR_EN_LO +: `FPU_FLAG_W];
    for (int s = 0; s < `FPU_FWD_SRCS; s++) begin
      fwd_bus[s] = rand_word();
    end
    for (int l = 0; l < `FPU_LANES; l++) begin
      en[l] = lane_mask[l];
      fwd_a_now[l] = (fwd_on && lane_mask[l]) ? rand_idx() : fwd_idx_t'(`FPU_FWD_NONE);
      fwd_a_old[l] = (fwd_on && lane_mask[l]) ? rand_idx() : fwd_idx_t'(`FPU_FWD_NONE);
      fwd_b_now[l] = (fwd_on && lane_mask[l]) ? rand_idx() : fwd_idx_t'(`FPU_FWD_NONE);
      fwd_b_old[l] = (fwd_on && lane_mask[l]) ? rand_idx() : fwd_idx_t'(`FPU_FWD_NONE);
      use_bx[l] = lane_mask[l] && ((bx_mode == 2) ? 1'($random(seed)) : (bx_mode == 1));
      if (lane_mask[l]) begin
        a[l] = rand_word();
        b[l] = rand_word();
        bx[l] = rand_word();
        if (op_sel < 0) begin
          op[l] = perm_op_t'(3'($unsigned($random(seed)) % 5));
        end else begin
          op[l] = perm_op_t'(op_sel[2:0]);
        end
        flags[l] = fpu_flags_t'($random(seed));
        tag[l] = next_tag[l];
        next_tag[l] = next_tag[l] + 1'b1;
        cur[l] = reference_model(a[l], b[l], bx[l], op[l], use_bx[l], fwd_a_now[l],
                                 fwd_a_old[l], fwd_b_now[l], fwd_b_old[l], fwd_bus,
                                 bus_prev, flags[l], tag[l], csr_en);
        // retire register loads one edge after the issue edge at cyc+1
        cur[l].due = cyc + 2;
        exp_q[l].push_back(cur[l]);
      end
    end
    #1;
    for (int l = 0; l < `FPU_LANES; l++) begin
      if (lane_mask[l]) begin
        assert (b_fwd[l] === cur[l].b_fwd) else begin
          $display("Fail b_fwd[%0d] got %h expected %h", l, b_fwd[l], cur[l].b_fwd);
          val_errs++;
        end
      end
    end
  endtask

  task automatic drain_lanes(input string what);
    int waited;
    waited = 0;
    while (pending() != 0 && waited < DRAIN_LIMIT) begin
      issue_cycle('0, 1'b0, 0, -1);
      waited++;
    end
    if (pending() != 0) begin
      $display("timeout: %s results not retired within %0d cycles", what, DRAIN_LIMIT);
      other_errs++;
      for (int l = 0; l < `FPU_LANES; l++) begin
        exp_q[l].delete();
      end
    end
  endtask

  task automatic set_fpcsr(input logic [31:0] v);
    @(negedge clk);
    fpcsr = v;
  endtask

  // scoreboard
  initial begin
    expect_t e;
    forever begin
      @(posedge clk);
      cyc++;
      #1;
      for (int l = 0; l < `FPU_LANES; l++) begin
        if (ret_en[l] === 1'b1) begin
          assert (exp_q[l].size() != 0) else begin
            $display("lane %0d retired a result that was never issued", l);
            other_errs++;
          end
          if (exp_q[l].size() != 0) begin
            e = exp_q[l].pop_front();
            assert (res[l] === e.res) else begin
              $display("Fail res[%0d] got %h expected %h", l, res[l], e.res);
              val_errs++;
            end
            assert (ret[l] === e.ret) else begin
              $display("Fail ret[%0d] got %h expected %h", l, ret[l], e.ret);
              val_errs++;
            end
            assert (cyc == e.due) else begin
              $display("lane %0d retired at edge %0d instead of edge %0d", l, cyc, e.due);
              other_errs++;
            end
          end
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    fpcsr = '0;
    for (int s = 0; s < `FPU_FWD_SRCS; s++) begin
      fwd_bus[s] = '0;
    end
    for (int l = 0; l < `FPU_LANES; l++) begin
      en[l] = 1'b0;
      op[l] = PERM_COPY_A;
      use_bx[l] = 1'b0;
      a[l] = '0;
      b[l] = '0;
      bx[l] = '0;
      fwd_a_now[l] = fwd_idx_t'(`FPU_FWD_NONE);
      fwd_a_old[l] = fwd_idx_t'(`FPU_FWD_NONE);
      fwd_b_now[l] = fwd_idx_t'(`FPU_FWD_NONE);
      fwd_b_old[l] = fwd_idx_t'(`FPU_FWD_NONE);
      flags[l] = '0;
      tag[l] = '0;
      next_tag[l] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // idle lanes must not raise ret_en
    repeat (12) issue_cycle('0, 1'b0, 0, -1);

    set_fpcsr(32'h003f_f800);
    for (int k = 0; k < 5; k++) begin
      issue_cycle('1, 1'b0, 0, k);
    end
    drain_lanes("permute op");

    repeat (40) issue_cycle('1, 1'b1, 0, -1);
    drain_lanes("forwarding");

    repeat (20) issue_cycle('1, 1'b1, 1, -1);
    drain_lanes("alternate operand");

    // none, all, then random enable fields with random other bits
    for (int k = 0; k < 5; k++) begin
      if (k == 0) begin
        set_fpcsr(32'h0000_0000);
      end else if (k == 1) begin
        set_fpcsr(32'h003f_f800);
      end else begin
        set_fpcsr($random(seed));
      end
      repeat (15) issue_cycle('1, 1'b1, 2, -1);
      drain_lanes("retire code");
    end

    set_fpcsr($random(seed));
    repeat (200) issue_cycle('1, 1'b1, 2, -1);
    drain_lanes("back-to-back");

    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+.
fpu_pkg.sv
fwd_bus_capture.sv
operand_forward.sv
perm_lane.sv
fpu_retire.sv
fpu_perm_unit.sv
tb_fpu_perm_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_fpu_perm_unit -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
  exit 0
else
  exit 1
fi
